// File: id_stage_top.f
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/operand_forward.sv
rtl/id_ex_reg.sv
rtl/id_stage_top.sv
test/id_stage_properties.sv
test/id_stage_tb.sv

// File: rtl/id_ex_reg.sv
`timescale 1ns/1ps
module id_ex_reg (
    input  logic           clk,
    input  logic           arst_n_i,
    input  id_pkg::id_ex_t d_i,
    output id_pkg::id_ex_t q_o
);

    // all zero is a nop, aluop and alusel both encode NOP as 0
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            q_o <= '0;
        end
        else
        begin
            q_o <= d_i;
        end
    end

endmodule

// File: rtl/id_pkg.sv
package id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // opcode bits 6:2
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // legal funct7 for shifts, alt also marks SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'h00,
        ALU_ADD   = 8'h01,
        ALU_SUB   = 8'h02,
        ALU_LES   = 8'h03,
        ALU_LESU  = 8'h04,
        ALU_XOR   = 8'h05,
        ALU_OR    = 8'h06,
        ALU_AND   = 8'h07,
        ALU_SFTL  = 8'h08,
        ALU_SFTR  = 8'h09,
        ALU_SFTSY = 8'h0a,   // arithmetic right
        ALU_JAL   = 8'h0b,
        ALU_JALR  = 8'h0c,
        ALU_AUIPC = 8'h0d,
        ALU_BEQ   = 8'h0e,
        ALU_BNE   = 8'h0f,
        ALU_BLT   = 8'h10,
        ALU_BGE   = 8'h11,
        ALU_BLTU  = 8'h12,
        ALU_BGEU  = 8'h13
    } aluop_e;

    typedef enum logic [2:0] {
        RES_NOP   = 3'd0,
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_MATH  = 3'd3,
        RES_JUMP  = 3'd4
    } alusel_e;

    typedef enum logic [2:0] {
        IMM_NONE   = 3'd0,
        IMM_I_SEXT = 3'd1,
        IMM_I_ZEXT = 3'd2,
        IMM_SHAMT  = 3'd3,
        IMM_U      = 3'd4,
        IMM_J      = 3'd5,   // offset only
        IMM_B      = 3'd6    // offset only
    } imm_kind_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    typedef struct packed {
        logic              wreg;
        logic [REG_AW-1:0] wd;
        logic [XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        logic              re;
        logic [REG_AW-1:0] addr;
    } rf_read_t;

    typedef struct packed {
        aluop_e            aluop;
        alusel_e           alusel;
        logic              wreg;
        logic [REG_AW-1:0] wd;
        logic              re1;
        logic              re2;
        imm_kind_e         imm_kind;
    } dec_ctrl_t;

    typedef struct packed {
        aluop_e            aluop;
        alusel_e           alusel;
        logic              wreg;
        logic [REG_AW-1:0] wd;
        logic [XLEN-1:0]   reg1;
        logic [XLEN-1:0]   reg2;
        logic [XLEN-1:0]   link_pc;
        logic [XLEN-1:0]   branch_offset;
    } id_ex_t;

    localparam dec_ctrl_t NOP_CTRL = '{
        aluop:    ALU_NOP,
        alusel:   RES_NOP,
        wreg:     1'b0,
        wd:       '0,
        re1:      1'b0,
        re2:      1'b0,
        imm_kind: IMM_NONE
    };

endpackage

// File: rtl/id_stage_top.sv
`timescale 1ns/1ps
module id_stage_top (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic [id_pkg::XLEN-1:0]     pc_i,
    input  logic [id_pkg::XLEN-1:0]     inst_i,
    input  logic [id_pkg::XLEN-1:0]     reg1_data_i,
    input  logic [id_pkg::XLEN-1:0]     reg2_data_i,
    input  id_pkg::fwd_t                ex_fwd_i,
    input  id_pkg::fwd_t                mem_fwd_i,
    output id_pkg::rf_read_t            rf_rd1_o,
    output id_pkg::rf_read_t            rf_rd2_o,
    output id_pkg::id_ex_t              id_ex_o
);

    id_pkg::inst_u           inst;
    id_pkg::dec_ctrl_t       ctrl;
    id_pkg::id_ex_t          id_ex_d;
    logic [id_pkg::XLEN-1:0] imm;
    logic [id_pkg::XLEN-1:0] branch_offset;
    logic [id_pkg::XLEN-1:0] link_pc;
    logic [id_pkg::XLEN-1:0] reg1;
    logic [id_pkg::XLEN-1:0] reg2;
    logic                    is_lui;

    assign inst   = inst_i;
    assign is_lui = (inst.r_fmt.opcode[6:2] == id_pkg::OPC_LUI);

    inst_decoder inst_decoder_i (
        .inst_i (inst),
        .ctrl_o (ctrl)
    );

    imm_gen imm_gen_i (
        .inst_i          (inst),
        .pc_i            (pc_i),
        .kind_i          (ctrl.imm_kind),
        .imm_o           (imm),
        .branch_offset_o (branch_offset),
        .link_pc_o       (link_pc)
    );

    // lui reads x0, its rs1 bits belong to the immediate
    assign rf_rd1_o.re   = ctrl.re1;
    assign rf_rd1_o.addr = (ctrl.re1 && !is_lui) ? inst.r_fmt.rs1 : '0;
    assign rf_rd2_o.re   = ctrl.re2;
    assign rf_rd2_o.addr = ctrl.re2 ? inst.r_fmt.rs2 : '0;

    operand_forward fwd1_i (
        .rd_i      (rf_rd1_o),
        .rf_data_i (reg1_data_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .imm_i     (imm),
        .operand_o (reg1)
    );

    operand_forward fwd2_i (
        .rd_i      (rf_rd2_o),
        .rf_data_i (reg2_data_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .imm_i     (imm),
        .operand_o (reg2)
    );

    assign id_ex_d = '{
        aluop:         ctrl.aluop,
        alusel:        ctrl.alusel,
        wreg:          ctrl.wreg,
        wd:            ctrl.wd,
        reg1:          reg1,
        reg2:          reg2,
        link_pc:       link_pc,
        branch_offset: branch_offset
    };

    id_ex_reg id_ex_reg_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .d_i      (id_ex_d),
        .q_o      (id_ex_o)
    );

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
module imm_gen (
    input  id_pkg::inst_u               inst_i,
    input  logic [id_pkg::XLEN-1:0]     pc_i,
    input  id_pkg::imm_kind_e           kind_i,
    output logic [id_pkg::XLEN-1:0]     imm_o,
    output logic [id_pkg::XLEN-1:0]     branch_offset_o,
    output logic [id_pkg::XLEN-1:0]     link_pc_o
);

    logic [4:0]              opc;
    logic [id_pkg::XLEN-1:0] j_off;
    logic [id_pkg::XLEN-1:0] b_off;
    logic                    has_link;

    assign opc = inst_i.i_fmt.opcode[6:2];

    // J layout sits in the I view, B layout in the R view
    assign j_off = {{12{inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.rs1, inst_i.i_fmt.funct3,
                    inst_i.i_fmt.imm12[0], inst_i.i_fmt.imm12[10:1], 1'b0};
    assign b_off = {{20{inst_i.r_fmt.funct7[6]}}, inst_i.r_fmt.rd[0],
                    inst_i.r_fmt.funct7[5:0], inst_i.r_fmt.rd[4:1], 1'b0};

    always_comb
    begin
        case (kind_i)
            id_pkg::IMM_I_SEXT: imm_o = {{20{inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
            id_pkg::IMM_I_ZEXT: imm_o = {20'h0, inst_i.i_fmt.imm12};
            id_pkg::IMM_SHAMT:  imm_o = {27'h0, inst_i.r_fmt.rs2};
            id_pkg::IMM_U:      imm_o = {inst_i.i_fmt.imm12, inst_i.i_fmt.rs1,
                                         inst_i.i_fmt.funct3, 12'h0};
            default:            imm_o = '0;
        endcase
    end

    assign branch_offset_o = (kind_i == id_pkg::IMM_J) ? j_off :
                             (kind_i == id_pkg::IMM_B) ? b_off : '0;

    assign has_link = (kind_i == id_pkg::IMM_J) || (kind_i == id_pkg::IMM_B) ||
                      (opc == id_pkg::OPC_JALR) || (opc == id_pkg::OPC_AUIPC);

    assign link_pc_o = has_link ? pc_i + 32'd4 : '0;

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
module inst_decoder (
    input  id_pkg::inst_u     inst_i,
    output id_pkg::dec_ctrl_t ctrl_o
);

    logic [4:0] opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;   // register form of the alu group

    assign opc    = inst_i.r_fmt.opcode[6:2];
    assign funct3 = inst_i.r_fmt.funct3;
    assign funct7 = inst_i.r_fmt.funct7;
    assign is_op  = (opc == id_pkg::OPC_OP);

    always_comb
    begin
        ctrl_o = id_pkg::NOP_CTRL;
        case (opc)
            id_pkg::OPC_OP_IMM, id_pkg::OPC_OP:
            begin
                ctrl_o.wreg = 1'b1;
                ctrl_o.wd   = inst_i.r_fmt.rd;
                ctrl_o.re1  = 1'b1;
                ctrl_o.re2  = is_op;
                case (funct3)
                    id_pkg::F3_ADD:
                    begin
                        ctrl_o.aluop    = (is_op && funct7[5]) ? id_pkg::ALU_SUB
                                                               : id_pkg::ALU_ADD;
                        ctrl_o.alusel   = id_pkg::RES_MATH;
                        ctrl_o.imm_kind = id_pkg::IMM_I_SEXT;
                    end
                    id_pkg::F3_SLL:
                    begin
                        ctrl_o.aluop    = id_pkg::ALU_SFTL;
                        ctrl_o.alusel   = id_pkg::RES_SHIFT;
                        ctrl_o.imm_kind = id_pkg::IMM_SHAMT;
                    end
                    id_pkg::F3_SLT, id_pkg::F3_SLTU:
                    begin
                        ctrl_o.aluop    = funct3[0] ? id_pkg::ALU_LESU : id_pkg::ALU_LES;
                        ctrl_o.alusel   = id_pkg::RES_MATH;
                        ctrl_o.imm_kind = id_pkg::IMM_I_SEXT;   // sltiu compares sext too
                    end
                    id_pkg::F3_SR:
                    begin
                        ctrl_o.aluop    = funct7[5] ? id_pkg::ALU_SFTSY : id_pkg::ALU_SFTR;
                        ctrl_o.alusel   = id_pkg::RES_SHIFT;
                        ctrl_o.imm_kind = id_pkg::IMM_SHAMT;
                    end
                    id_pkg::F3_XOR:
                    begin
                        ctrl_o.aluop    = id_pkg::ALU_XOR;
                        ctrl_o.alusel   = id_pkg::RES_LOGIC;
                        ctrl_o.imm_kind = id_pkg::IMM_I_ZEXT;
                    end
                    id_pkg::F3_OR:
                    begin
                        ctrl_o.aluop    = id_pkg::ALU_OR;
                        ctrl_o.alusel   = id_pkg::RES_LOGIC;
                        ctrl_o.imm_kind = id_pkg::IMM_I_ZEXT;
                    end
                    default:   // F3_AND
                    begin
                        ctrl_o.aluop    = id_pkg::ALU_AND;
                        ctrl_o.alusel   = id_pkg::RES_LOGIC;
                        ctrl_o.imm_kind = id_pkg::IMM_I_ZEXT;
                    end
                endcase
                if (is_op)
                begin
                    ctrl_o.imm_kind = id_pkg::IMM_NONE;   // rs2 replaces the immediate
                end
                if (is_op && funct3 == id_pkg::F3_SR &&
                    funct7 != id_pkg::F7_BASE && funct7 != id_pkg::F7_ALT)
                begin
                    ctrl_o = id_pkg::NOP_CTRL;
                end
            end
            id_pkg::OPC_LUI:
            begin
                // x0 | imm, reg1 port held at address 0
                ctrl_o.aluop    = id_pkg::ALU_OR;
                ctrl_o.alusel   = id_pkg::RES_LOGIC;
                ctrl_o.wreg     = 1'b1;
                ctrl_o.wd       = inst_i.r_fmt.rd;
                ctrl_o.re1      = 1'b1;
                ctrl_o.imm_kind = id_pkg::IMM_U;
            end
            id_pkg::OPC_AUIPC:
            begin
                ctrl_o.aluop    = id_pkg::ALU_AUIPC;
                ctrl_o.alusel   = id_pkg::RES_MATH;
                ctrl_o.wreg     = 1'b1;
                ctrl_o.wd       = inst_i.r_fmt.rd;
                ctrl_o.imm_kind = id_pkg::IMM_U;
            end
            id_pkg::OPC_JAL:
            begin
                ctrl_o.aluop    = id_pkg::ALU_JAL;
                ctrl_o.alusel   = id_pkg::RES_JUMP;
                ctrl_o.wreg     = 1'b1;
                ctrl_o.wd       = inst_i.r_fmt.rd;
                ctrl_o.imm_kind = id_pkg::IMM_J;
            end
            id_pkg::OPC_JALR:
            begin
                ctrl_o.aluop    = id_pkg::ALU_JALR;
                ctrl_o.alusel   = id_pkg::RES_JUMP;
                ctrl_o.wreg     = 1'b1;
                ctrl_o.wd       = inst_i.r_fmt.rd;
                ctrl_o.re1      = 1'b1;
                ctrl_o.imm_kind = id_pkg::IMM_I_SEXT;
            end
            id_pkg::OPC_BRANCH:
            begin
                ctrl_o.alusel   = id_pkg::RES_JUMP;
                ctrl_o.re1      = 1'b1;
                ctrl_o.re2      = 1'b1;
                ctrl_o.imm_kind = id_pkg::IMM_B;
                case (funct3)
                    id_pkg::F3_BEQ:  ctrl_o.aluop = id_pkg::ALU_BEQ;
                    id_pkg::F3_BNE:  ctrl_o.aluop = id_pkg::ALU_BNE;
                    id_pkg::F3_BLT:  ctrl_o.aluop = id_pkg::ALU_BLT;
                    id_pkg::F3_BGE:  ctrl_o.aluop = id_pkg::ALU_BGE;
                    id_pkg::F3_BLTU: ctrl_o.aluop = id_pkg::ALU_BLTU;
                    id_pkg::F3_BGEU: ctrl_o.aluop = id_pkg::ALU_BGEU;
                    default:         ctrl_o = id_pkg::NOP_CTRL;
                endcase
            end
            default: ctrl_o = id_pkg::NOP_CTRL;
        endcase
    end

endmodule

// File: rtl/operand_forward.sv
`timescale 1ns/1ps
module operand_forward (
    input  id_pkg::rf_read_t            rd_i,
    input  logic [id_pkg::XLEN-1:0]     rf_data_i,
    input  id_pkg::fwd_t                ex_fwd_i,
    input  id_pkg::fwd_t                mem_fwd_i,
    input  logic [id_pkg::XLEN-1:0]     imm_i,
    output logic [id_pkg::XLEN-1:0]     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // x0 is never a forward target
    assign ex_hit  = rd_i.re && ex_fwd_i.wreg && (ex_fwd_i.wd == rd_i.addr) &&
                     (rd_i.addr != '0);
    assign mem_hit = rd_i.re && mem_fwd_i.wreg && (mem_fwd_i.wd == rd_i.addr) &&
                     (rd_i.addr != '0);

    always_comb
    begin
        if (ex_hit)
        begin
            operand_o = ex_fwd_i.wdata;   // youngest result wins
        end
        else if (mem_hit)
        begin
            operand_o = mem_fwd_i.wdata;
        end
        else if (rd_i.re)
        begin
            operand_o = rf_data_i;
        end
        else
        begin
            operand_o = imm_i;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ID stage testbench, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module id_stage_tb -f id_stage_top.f -o id_stage_sim \
    && ./obj_dir/id_stage_sim +verilator+error+limit+100 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/id_stage_properties.sv
`timescale 1ns/1ps
module id_stage_properties (
    input logic             clk,
    input logic             arst_n_i,
    input logic [31:0]      inst_i,
    input id_pkg::fwd_t     ex_fwd_i,
    input id_pkg::fwd_t     mem_fwd_i,
    input id_pkg::rf_read_t rd1_i,
    input id_pkg::rf_read_t rd2_i,
    input logic [31:0]      reg1_i,
    input logic [31:0]      reg2_i,
    input id_pkg::id_ex_t   id_ex_i
);

    int         assert_fails = 0;
    logic [4:0] opc;
    logic       known_opc;
    logic       bad_inst;
    logic       ex_hit1;
    logic       mem_hit1;
    logic       ex_hit2;
    logic       mem_hit2;

    assign opc       = inst_i[6:2];
    assign known_opc = opc inside {id_pkg::OPC_OP_IMM, id_pkg::OPC_OP, id_pkg::OPC_LUI,
                                   id_pkg::OPC_AUIPC, id_pkg::OPC_JAL, id_pkg::OPC_JALR,
                                   id_pkg::OPC_BRANCH};
    // unknown opcode, or srl/sra with a funct7 other than 0x00 and 0x20
    assign bad_inst  = !known_opc || (opc == id_pkg::OPC_OP && inst_i[14:12] == id_pkg::F3_SR &&
                       inst_i[31:25] != 7'h00 && inst_i[31:25] != 7'h20);

    assign ex_hit1  = rd1_i.re && ex_fwd_i.wreg && ex_fwd_i.wd == rd1_i.addr && rd1_i.addr != 0;
    assign mem_hit1 = rd1_i.re && mem_fwd_i.wreg && mem_fwd_i.wd == rd1_i.addr && rd1_i.addr != 0;
    assign ex_hit2  = rd2_i.re && ex_fwd_i.wreg && ex_fwd_i.wd == rd2_i.addr && rd2_i.addr != 0;
    assign mem_hit2 = rd2_i.re && mem_fwd_i.wreg && mem_fwd_i.wd == rd2_i.addr && rd2_i.addr != 0;

    a_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!id_ex_i.wreg && id_ex_i.aluop == id_pkg::ALU_NOP))
    else
    begin
        assert_fails++;
        $error("ID/EX word is not a nop during reset");
    end

    a_rs1_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rd1_i.re && opc != id_pkg::OPC_LUI) |-> rd1_i.addr == inst_i[19:15])
    else
    begin
        assert_fails++;
        $error("read port 1 address differs from rs1");
    end

    a_fwd_priority: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!ex_hit1 || reg1_i == ex_fwd_i.wdata) && (ex_hit1 || !mem_hit1 ||
        reg1_i == mem_fwd_i.wdata) && (!ex_hit2 || reg2_i == ex_fwd_i.wdata) &&
        (ex_hit2 || !mem_hit2 || reg2_i == mem_fwd_i.wdata))
    else
    begin
        assert_fails++;
        $error("operand ignores the EX over MEM forward priority");
    end

    a_invalid_no_read: assert property (@(posedge clk) disable iff (!arst_n_i)
        bad_inst |-> (!rd1_i.re && !rd2_i.re))
    else
    begin
        assert_fails++;
        $error("invalid instruction enables a register read");
    end

    a_invalid_nop: assert property (@(posedge clk) disable iff (!arst_n_i)
        bad_inst |=> (!id_ex_i.wreg && id_ex_i.aluop == id_pkg::ALU_NOP))
    else
    begin
        assert_fails++;
        $error("invalid instruction did not become a nop");
    end

endmodule

bind id_stage_top id_stage_properties props_i (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .inst_i    (inst_i),
    .ex_fwd_i  (ex_fwd_i),
    .mem_fwd_i (mem_fwd_i),
    .rd1_i     (rf_rd1_o),
    .rd2_i     (rf_rd2_o),
    .reg1_i    (reg1),
    .reg2_i    (reg2),
    .id_ex_i   (id_ex_o)
);

// File: test/id_stage_tb.sv
`timescale 1ns/1ps
module id_stage_tb;

    localparam int MAX_CYCLES = 200;   // about 45 cycles of tests, wide margin

    logic              clk;
    logic              arst_n_i;
    logic [31:0]       pc_i;
    logic [31:0]       inst_i;
    logic [31:0]       reg1_data_i;
    logic [31:0]       reg2_data_i;
    id_pkg::fwd_t      ex_fwd_i;
    id_pkg::fwd_t      mem_fwd_i;
    id_pkg::rf_read_t  rf_rd1_o;
    id_pkg::rf_read_t  rf_rd2_o;
    id_pkg::id_ex_t    id_ex_o;

    integer seed;
    int     cycles = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_errs = 0;
    string  cur_test;

    function automatic logic [31:0] rf_value(input logic [4:0] addr);
        return 32'hA500_0000 + {27'd0, addr};
    endfunction

    // register file model
    assign reg1_data_i = rf_value(rf_rd1_o.addr);
    assign reg2_data_i = rf_value(rf_rd2_o.addr);

    id_stage_top id_stage_top_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .rf_rd1_o    (rf_rd1_o),
        .rf_rd2_o    (rf_rd2_o),
        .id_ex_o     (id_ex_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // RV32I encoders
    function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] opc);
        return {imm12, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, id_pkg::OPC_OP, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], id_pkg::OPC_BRANCH, 2'b11};
    endfunction

    function automatic id_pkg::id_ex_t pack_exp(input id_pkg::aluop_e op,
                                                input id_pkg::alusel_e sel,
                                                input logic wreg, input logic [4:0] wd,
                                                input logic [31:0] r1, input logic [31:0] r2,
                                                input logic [31:0] link,
                                                input logic [31:0] boff);
        return '{aluop: op, alusel: sel, wreg: wreg, wd: wd, reg1: r1, reg2: r2,
                 link_pc: link, branch_offset: boff};
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test;
        tests_run++;
        if (test_errs == 0)
        begin
            $display("PASS %s", cur_test);
        end
        else
        begin
            tests_failed++;
            $display("FAIL %s with %0d mismatches", cur_test, test_errs);
        end
    endtask

    task automatic compare_word(input id_pkg::id_ex_t exp);
        assert (id_ex_o == exp)
        else
        begin
            $display("ERROR %s expected %h actual %h", cur_test, exp, id_ex_o);
            test_errs++;
        end
    endtask

    // drive on a falling edge, result is registered one rising edge later
    task automatic run_case(input logic [31:0] inst, input id_pkg::id_ex_t exp);
        inst_i = inst;
        @(negedge clk);
        compare_word(exp);
    endtask

    task automatic check_op_imm(input logic [2:0] f3, input logic [6:0] f7,
                                input id_pkg::aluop_e op, input id_pkg::alusel_e sel,
                                input int kind);
        logic [31:0] r;
        logic [11:0] imm12;
        logic [31:0] opnd;
        r     = $random(seed);
        imm12 = (kind == 2) ? {f7, r[14:10]} : r[21:10];
        case (kind)
            0:       opnd = {{20{imm12[11]}}, imm12};
            1:       opnd = {20'd0, imm12};
            default: opnd = {27'd0, imm12[4:0]};   // shift amount
        endcase
        run_case(enc_i(imm12, r[4:0], f3, r[9:5], id_pkg::OPC_OP_IMM),
                 pack_exp(op, sel, 1'b1, r[9:5], rf_value(r[4:0]), opnd, '0, '0));
    endtask

    task automatic check_op(input logic [2:0] f3, input logic [6:0] f7,
                            input id_pkg::aluop_e op, input id_pkg::alusel_e sel);
        logic [31:0] r;
        r = $random(seed);
        run_case(enc_r(f7, r[14:10], r[4:0], f3, r[9:5]),
                 pack_exp(op, sel, 1'b1, r[9:5], rf_value(r[4:0]), rf_value(r[14:10]),
                          '0, '0));
    endtask

    task automatic check_branch(input logic [2:0] f3, input id_pkg::aluop_e op,
                                input logic [31:0] off);
        logic [31:0] r;
        r = $random(seed);
        run_case(enc_b(off, r[14:10], r[4:0], f3),
                 pack_exp(op, id_pkg::RES_JUMP, 1'b0, 5'd0, rf_value(r[4:0]),
                          rf_value(r[14:10]), pc_i + 32'd4, off));
    endtask

    initial
    begin
        seed      = 27;
        arst_n_i  = 1'b1;
        pc_i      = 32'h0000_1000;
        inst_i    = '0;
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        @(negedge clk);

        begin_test("reset");
        // a live word in the register so the clear shows
        run_case(enc_i(12'h123, 5'd1, id_pkg::F3_ADD, 5'd2, id_pkg::OPC_OP_IMM),
                 pack_exp(id_pkg::ALU_ADD, id_pkg::RES_MATH, 1'b1, 5'd2, rf_value(5'd1),
                          32'h0000_0123, '0, '0));
        inst_i   = '0;
        arst_n_i = 1'b0;
        #1;
        compare_word('0);   // cleared before the next clock edge
        repeat (3)
        begin
            @(negedge clk);
            compare_word('0);
        end
        arst_n_i = 1'b1;
        run_case(32'h0, '0);   // opcode 0 decodes to a nop
        end_test;

        begin_test("i_type_alu");
        check_op_imm(id_pkg::F3_ADD, 7'h00, id_pkg::ALU_ADD, id_pkg::RES_MATH, 0);
        check_op_imm(id_pkg::F3_SLT, 7'h00, id_pkg::ALU_LES, id_pkg::RES_MATH, 0);
        check_op_imm(id_pkg::F3_SLTU, 7'h00, id_pkg::ALU_LESU, id_pkg::RES_MATH, 0);
        check_op_imm(id_pkg::F3_XOR, 7'h00, id_pkg::ALU_XOR, id_pkg::RES_LOGIC, 1);
        check_op_imm(id_pkg::F3_OR, 7'h00, id_pkg::ALU_OR, id_pkg::RES_LOGIC, 1);
        check_op_imm(id_pkg::F3_AND, 7'h00, id_pkg::ALU_AND, id_pkg::RES_LOGIC, 1);
        check_op_imm(id_pkg::F3_SLL, 7'h00, id_pkg::ALU_SFTL, id_pkg::RES_SHIFT, 2);
        check_op_imm(id_pkg::F3_SR, 7'h00, id_pkg::ALU_SFTR, id_pkg::RES_SHIFT, 2);
        check_op_imm(id_pkg::F3_SR, 7'h20, id_pkg::ALU_SFTSY, id_pkg::RES_SHIFT, 2);
        end_test;

        begin_test("r_type_alu");
        check_op(id_pkg::F3_ADD, 7'h00, id_pkg::ALU_ADD, id_pkg::RES_MATH);
        check_op(id_pkg::F3_ADD, 7'h20, id_pkg::ALU_SUB, id_pkg::RES_MATH);
        check_op(id_pkg::F3_SLL, 7'h00, id_pkg::ALU_SFTL, id_pkg::RES_SHIFT);
        check_op(id_pkg::F3_SLT, 7'h00, id_pkg::ALU_LES, id_pkg::RES_MATH);
        check_op(id_pkg::F3_SLTU, 7'h00, id_pkg::ALU_LESU, id_pkg::RES_MATH);
        check_op(id_pkg::F3_XOR, 7'h00, id_pkg::ALU_XOR, id_pkg::RES_LOGIC);
        check_op(id_pkg::F3_SR, 7'h00, id_pkg::ALU_SFTR, id_pkg::RES_SHIFT);
        check_op(id_pkg::F3_SR, 7'h20, id_pkg::ALU_SFTSY, id_pkg::RES_SHIFT);
        check_op(id_pkg::F3_OR, 7'h00, id_pkg::ALU_OR, id_pkg::RES_LOGIC);
        check_op(id_pkg::F3_AND, 7'h00, id_pkg::ALU_AND, id_pkg::RES_LOGIC);
        end_test;

        begin_test("forwarding");
        ex_fwd_i  = '{wreg: 1'b1, wd: 5'd5, wdata: 32'h1111_1111};
        mem_fwd_i = '{wreg: 1'b1, wd: 5'd5, wdata: 32'h2222_2222};
        run_case(enc_r(7'h00, 5'd6, 5'd5, id_pkg::F3_ADD, 5'd3),
                 pack_exp(id_pkg::ALU_ADD, id_pkg::RES_MATH, 1'b1, 5'd3, 32'h1111_1111,
                          rf_value(5'd6), '0, '0));
        ex_fwd_i  = '{wreg: 1'b0, wd: 5'd6, wdata: 32'h4444_4444};   // not writing
        mem_fwd_i = '{wreg: 1'b1, wd: 5'd6, wdata: 32'h3333_3333};
        run_case(enc_r(7'h00, 5'd6, 5'd5, id_pkg::F3_ADD, 5'd3),
                 pack_exp(id_pkg::ALU_ADD, id_pkg::RES_MATH, 1'b1, 5'd3, rf_value(5'd5),
                          32'h3333_3333, '0, '0));
        ex_fwd_i  = '{wreg: 1'b1, wd: 5'd0, wdata: 32'hDEAD_0000};
        mem_fwd_i = '{wreg: 1'b1, wd: 5'd0, wdata: 32'hBEEF_0000};
        run_case(enc_r(7'h00, 5'd7, 5'd0, id_pkg::F3_ADD, 5'd3),
                 pack_exp(id_pkg::ALU_ADD, id_pkg::RES_MATH, 1'b1, 5'd3, rf_value(5'd0),
                          rf_value(5'd7), '0, '0));
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        end_test;

        begin_test("jumps_branches");
        pc_i = 32'h0000_2FFC;
        run_case({1'b1, 10'h11A, 1'b0, 8'h81, 5'd1, id_pkg::OPC_JAL, 2'b11},   // -0x7EDCC
                 pack_exp(id_pkg::ALU_JAL, id_pkg::RES_JUMP, 1'b1, 5'd1, '0, '0,
                          32'h0000_3000, 32'hFFF8_1234));
        run_case(enc_i(12'h010, 5'd9, 3'b000, 5'd1, id_pkg::OPC_JALR),
                 pack_exp(id_pkg::ALU_JALR, id_pkg::RES_JUMP, 1'b1, 5'd1, rf_value(5'd9),
                          32'h0000_0010, 32'h0000_3000, '0));
        run_case({20'h8765_4, 5'd12, id_pkg::OPC_AUIPC, 2'b11},
                 pack_exp(id_pkg::ALU_AUIPC, id_pkg::RES_MATH, 1'b1, 5'd12, 32'h8765_4000,
                          32'h8765_4000, 32'h0000_3000, '0));
        run_case({20'hABCD_E, 5'd13, id_pkg::OPC_LUI, 2'b11},
                 pack_exp(id_pkg::ALU_OR, id_pkg::RES_LOGIC, 1'b1, 5'd13, rf_value(5'd0),
                          32'hABCD_E000, '0, '0));
        check_branch(id_pkg::F3_BEQ, id_pkg::ALU_BEQ, 32'hFFFF_F800);
        check_branch(id_pkg::F3_BNE, id_pkg::ALU_BNE, 32'h0000_0FFE);
        check_branch(id_pkg::F3_BLT, id_pkg::ALU_BLT, 32'hFFFF_F000);
        check_branch(id_pkg::F3_BGE, id_pkg::ALU_BGE, 32'h0000_0A52);
        check_branch(id_pkg::F3_BLTU, id_pkg::ALU_BLTU, 32'hFFFF_FFFE);
        check_branch(id_pkg::F3_BGEU, id_pkg::ALU_BGEU, 32'h0000_0800);
        pc_i = 32'h0000_1000;
        end_test;

        begin_test("invalid_inst");
        run_case(32'h0000_2083, '0);   // load word, dropped opcode
        run_case(enc_r(7'h01, 5'd4, 5'd2, id_pkg::F3_SR, 5'd8), '0);
        run_case(enc_b(32'h0000_0010, 5'd4, 5'd2, 3'b010), '0);
        end_test;

        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed,
                 id_stage_top_i.props_i.assert_fails);
        if (tests_failed == 0 && id_stage_top_i.props_i.assert_fails == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
